// ==== bench/obj_tb.sv ====
// ************************************************************
// Object table testbench
// Drives CPU writes, bank swaps and line scans into obj_top and
// checks reads and hit lists against a shadow of both banks.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_tb;

    import obj_cfg_pkg::*;

    localparam int OBJ_COUNT  = 16;
    localparam int HIT_MAX    = 4;
    localparam int HEIGHT     = 16;
    localparam int SCAN_LIMIT = 400;

    logic       clk_cpu;
    logic       arst_n;
    logic       frame_start;
    logic       line_start;
    pos_t       line;
    logic       cs;
    logic [1:0] dsn;
    logic       main_rnw;
    cpu_addr_t  main_addr;
    word_t      main_dout;
    logic       ok;
    word_t      dout2cpu;
    logic       hit_valid;
    pos_t       hit_x;
    word_t      hit_code;
    word_t      hit_attr;
    logic       scan_done;
    logic       overflow;

    // Shadow of both banks, indexed by physical address.
    // Bit 12 of the index is the physical bank.
    word_t model [0:8191];
    logic  model_obank;

    int errors;
    int timeouts;
    bit aborted;

    obj_top #(.OBJ_COUNT(OBJ_COUNT), .HIT_MAX(HIT_MAX)) DUT (
        .clk_cpu     (clk_cpu),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .line_start  (line_start),
        .line        (line),
        .cs          (cs),
        .dsn         (dsn),
        .main_rnw    (main_rnw),
        .main_addr   (main_addr),
        .main_dout   (main_dout),
        .ok          (ok),
        .dout2cpu    (dout2cpu),
        .hit_valid   (hit_valid),
        .hit_x       (hit_x),
        .hit_code    (hit_code),
        .hit_attr    (hit_attr),
        .scan_done   (scan_done),
        .overflow    (overflow)
    );

    // 4 ns period.
    always #2 clk_cpu = ~clk_cpu;

    task automatic report_value(input string test, input int expected, input int actual);
        $display("ERR %s expected %0h actual %0h", test, expected, actual);
        errors++;
    endtask

    task automatic report_fail(input string text);
        $display("Check failed: %s", text);
        errors++;
    endtask

    // Acknowledge trails chip select by exactly one cycle.
    a_ok_echo: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        ok == $past(cs))
        else report_fail("ok did not follow cs by one cycle");

    // Overflow is only meaningful together with scan_done.
    a_ovf_done: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        overflow |-> scan_done)
        else report_fail("overflow high without scan_done");

    // All hits come out before the done pulse.
    a_hit_order: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        scan_done |-> !hit_valid)
        else report_fail("hit_valid together with scan_done");

    a_done_pulse: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        scan_done |=> !scan_done)
        else report_fail("scan_done longer than one cycle");

    // One CPU write, then the shadow takes the enabled bytes.
    task automatic cpu_write(input cpu_addr_t addr, input word_t data,
                             input logic [1:0] lanes_n);
        logic [12:0] phys;
        phys = {model_obank ^ addr[12], addr[11:0]};
        @(posedge clk_cpu);
        #1;
        cs        = 1'b1;
        main_rnw  = 1'b0;
        dsn       = lanes_n;
        main_addr = addr;
        main_dout = data;
        @(posedge clk_cpu);
        #1;
        cs       = 1'b0;
        main_rnw = 1'b1;
        dsn      = 2'b11;
        if (!lanes_n[0]) begin
            model[phys][7:0] = data[7:0];
        end
        if (!lanes_n[1]) begin
            model[phys][15:8] = data[15:8];
        end
    endtask

    // Read data is checked in the cycle where ok is high.
    task automatic cpu_read_check(input cpu_addr_t addr, input string name);
        word_t exp_word;
        exp_word = model[{model_obank ^ addr[12], addr[11:0]}];
        @(posedge clk_cpu);
        #1;
        cs        = 1'b1;
        main_rnw  = 1'b1;
        dsn       = 2'b00;
        main_addr = addr;
        @(posedge clk_cpu);
        #1;
        cs = 1'b0;
        assert (ok) else report_fail("ok low one cycle after a read");
        assert (dout2cpu == exp_word) else report_value(name, int'(exp_word), int'(dout2cpu));
    endtask

    task automatic write_entry(input bit front, input int idx, input pos_t x, input pos_t y,
                               input word_t code, input word_t attr);
        cpu_addr_t base;
        base = {front, 12'(idx * 4)};
        cpu_write(base, {6'd0, x}, 2'b00);
        cpu_write(base + 13'd1, {6'd0, y}, 2'b00);
        cpu_write(base + 13'd2, code, 2'b00);
        cpu_write(base + 13'd3, attr, 2'b00);
    endtask

    // Random attribute with an upper byte that is never the end mark.
    function automatic word_t rand_attr();
        return {8'($urandom % 255), 8'($urandom)};
    endfunction

    // Object rows start at y and wrap past the last of the 1024 lines.
    function automatic bit line_in_object(input pos_t l, input pos_t y);
        bit hit;
        hit = 1'b0;
        for (int row = 0; row < HEIGHT; row++) begin
            if ((int'(y) + row) % 1024 == int'(l)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic swap_frame();
        @(posedge clk_cpu);
        #1;
        frame_start = 1'b1;
        @(posedge clk_cpu);
        #1;
        frame_start = 1'b0;
        model_obank = ~model_obank;
    endtask

    // Expected hit list from the shadow front bank, then one scan of line l.
    task automatic run_line(input pos_t l, input string name);
        pos_t        ex_x[$];
        word_t       ex_code[$];
        word_t       ex_attr[$];
        logic [12:0] base;
        bit          ex_ovf;
        bit          stop;
        bit          done;
        int          i;
        int          n_hit;
        int          cyc;
        if (aborted) begin
            return;
        end
        ex_ovf = 1'b0;
        stop   = 1'b0;
        i      = 0;
        while (!stop && i < OBJ_COUNT) begin
            base = {~model_obank, 12'(i * 4)};
            if (model[base + 13'd3][15:8] == 8'hff) begin
                stop = 1'b1;
            end else begin
                if (line_in_object(l, model[base + 13'd1][9:0])) begin
                    ex_x.push_back(model[base][9:0]);
                    ex_code.push_back(model[base + 13'd2]);
                    ex_attr.push_back(model[base + 13'd3]);
                    if (ex_x.size() == HIT_MAX) begin
                        ex_ovf = 1'b1;
                        stop   = 1'b1;
                    end
                end
            end
            i++;
        end
        @(posedge clk_cpu);
        #1;
        line_start = 1'b1;
        line       = l;
        @(posedge clk_cpu);
        #1;
        line_start = 1'b0;
        n_hit = 0;
        done  = 1'b0;
        cyc   = 0;
        while (!done && cyc < SCAN_LIMIT) begin
            if (hit_valid) begin
                if (n_hit < ex_x.size()) begin
                    assert (hit_x == ex_x[n_hit])
                        else report_value({name, " x"}, int'(ex_x[n_hit]), int'(hit_x));
                    assert (hit_code == ex_code[n_hit])
                        else report_value({name, " code"}, int'(ex_code[n_hit]), int'(hit_code));
                    assert (hit_attr == ex_attr[n_hit])
                        else report_value({name, " attr"}, int'(ex_attr[n_hit]), int'(hit_attr));
                end
                n_hit++;
            end
            if (scan_done) begin
                done = 1'b1;
                assert (n_hit == ex_x.size())
                    else report_value({name, " hit count"}, ex_x.size(), n_hit);
                assert (overflow == ex_ovf)
                    else report_value({name, " overflow"}, int'(ex_ovf), int'(overflow));
            end else begin
                @(posedge clk_cpu);
                #1;
                cyc++;
            end
        end
        if (!done) begin
            $display("Timeout: no scan_done for line %0d in %s", l, name);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int   i;
        pos_t y;
        void'($urandom(32'hc0241142));
        errors      = 0;
        timeouts    = 0;
        aborted     = 1'b0;
        model_obank = 1'b0;
        clk_cpu     = 1'b0;
        arst_n      = 1'b0;
        frame_start = 1'b0;
        line_start  = 1'b0;
        line        = '0;
        cs          = 1'b0;
        dsn         = 2'b11;
        main_rnw    = 1'b1;
        main_addr   = '0;
        main_dout   = '0;
        repeat (4) @(posedge clk_cpu);
        #1;
        arst_n = 1'b1;
        assert (!ok) else report_value("reset ok", 0, int'(ok));
        assert (!hit_valid) else report_value("reset hit_valid", 0, int'(hit_valid));
        assert (!scan_done) else report_value("reset scan_done", 0, int'(scan_done));
        assert (!overflow) else report_value("reset overflow", 0, int'(overflow));

        // Byte lanes, then one word in each bank.
        cpu_write(13'h0400, 16'h1234, 2'b00);
        cpu_write(13'h0400, 16'hab55, 2'b10);
        cpu_write(13'h0400, 16'h77cc, 2'b01);
        cpu_read_check(13'h0400, "lane merge");
        cpu_write(13'h1400, 16'h5a5a, 2'b00);
        cpu_read_check(13'h1400, "front word");
        cpu_read_check(13'h0400, "back word");

        // Empty front table, random table A behind it.
        write_entry(1'b1, 0, '0, '0, '0, 16'hff00);
        run_line(10'd20, "empty front");
        for (i = 0; i < 10; i++) begin
            y = (i == 2) ? 10'd1016 : 10'($urandom % 64);
            write_entry(1'b0, i, 10'($urandom), y, 16'($urandom), rand_attr());
        end
        write_entry(1'b0, 10, '0, '0, '0, 16'hff00);
        run_line(10'd20, "before swap");
        swap_frame();
        cpu_read_check(13'h1001, "front y0");
        cpu_read_check(13'h0003, "back end mark");
        run_line(10'd3, "wrap line");
        run_line(10'd1020, "bottom line");
        for (i = 0; i < 8; i++) begin
            run_line(10'($urandom % 80), "random line");
        end

        // Table B ends early at entry 2.
        write_entry(1'b0, 0, 10'($urandom), 10'd195, 16'($urandom), rand_attr());
        write_entry(1'b0, 1, 10'($urandom), 10'd190, 16'($urandom), rand_attr());
        write_entry(1'b0, 2, 10'($urandom), 10'd195, 16'($urandom), 16'hff12);
        write_entry(1'b0, 3, 10'($urandom), 10'd195, 16'($urandom), rand_attr());
        swap_frame();
        run_line(10'd200, "end mark");

        // Table C fills all entries, six at line 300 and ten at 600.
        for (i = 0; i < OBJ_COUNT; i++) begin
            y = (i < 6) ? 10'd300 : 10'd600;
            write_entry(1'b0, i, 10'($urandom), y, 16'($urandom), rand_attr());
        end
        swap_frame();
        run_line(10'd305, "hit limit");
        run_line(10'd700, "table size");
        run_line(10'd610, "hit limit late");

        $display("obj_tb: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/obj_cfg_pkg.sv
src/obj_fmt_pkg.sv
src/dual_port_ram.sv
src/obj_ram.sv
src/obj_ctrl.sv
src/obj_scan.sv
src/obj_top.sv
bench/obj_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the object table testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_tb -f compile.f -o obj_sim

./obj_dir/obj_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log."
    exit 1
fi

echo "Simulation passed."

// ==== src/dual_port_ram.sv ====
// ************************************************************
// Dual-port RAM
// Storage array with a write and a registered read on each port.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram #(
    parameter int DW = 8,
    parameter int AW = 13
) (
    input  wire          clk_cpu,
    // Port 0.
    input  wire [DW-1:0] data0,
    input  wire [AW-1:0] addr0,
    input  wire          we0,
    output logic [DW-1:0] q0,
    // Port 1.
    input  wire [DW-1:0] data1,
    input  wire [AW-1:0] addr1,
    input  wire          we1,
    output logic [DW-1:0] q1
);

    logic [DW-1:0] mem [0:(2**AW)-1];

    // Both ports share one process so the array has a single driver.
    // A read during a write to the same address returns the old word.
    always_ff @(posedge clk_cpu) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        if (we1) begin
            mem[addr1] <= data1;
        end
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

// ==== src/obj_cfg_pkg.sv ====
// ************************************************************
// Object table configuration
// Width types and default sizes shared by the object table,
// its controller and the scanner.
// ************************************************************
`default_nettype none

package obj_cfg_pkg;

    // One table word as seen by the CPU and the scanner.
    typedef logic [15:0] word_t;

    // CPU word address.
    // Bit 12 picks the front or back bank relative to obank.
    typedef logic [12:0] cpu_addr_t;

    // Word address inside one bank.
    typedef logic [11:0] scan_addr_t;

    // Screen coordinate or line number.
    typedef logic [9:0] pos_t;

    // Default number of entries walked on every line.
    localparam int DEF_OBJ_COUNT = 1024;

    // Default limit on objects reported for one line.
    localparam int DEF_HIT_MAX = 16;

endpackage

`default_nettype wire

// ==== src/obj_ctrl.sv ====
// ************************************************************
// Object scan control
// Swaps banks at frame start, runs one scan per line start and
// turns scanner results into hit and done pulses.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_ctrl #(
    parameter int OBJ_COUNT = obj_cfg_pkg::DEF_OBJ_COUNT,
    parameter int HIT_MAX   = obj_cfg_pkg::DEF_HIT_MAX
) (
    input  wire                     clk_cpu,
    input  wire                     arst_n,
    input  wire                     frame_start,
    input  wire                     line_start,
    input  wire obj_cfg_pkg::pos_t  line,
    // Results from the scanner.
    input  wire                     entry_done,
    input  wire                     entry_hit,
    input  wire                     entry_last,
    output logic                    obank,
    output logic                    scan_run,
    output obj_cfg_pkg::pos_t       scan_line,
    output logic                    hit_valid,
    output logic                    scan_done,
    output logic                    overflow
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_FINISH
    } state_t;

    localparam int ECW = $clog2(OBJ_COUNT + 1);
    localparam int HCW = $clog2(HIT_MAX + 1);

    state_t         state;
    logic [ECW-1:0] entry_cnt;
    logic [HCW-1:0] hit_cnt;
    logic           ovf_flag;
    logic           last_entry;
    logic           last_hit;

    // Scanner fetches only while in the scan state.
    assign scan_run = (state == S_SCAN);

    // Scanner holds x, code and attr until its next entry, so the hit goes out unregistered.
    assign hit_valid = scan_run & entry_done & entry_hit;

    // Finish lasts one cycle and carries the overflow flag.
    assign scan_done = (state == S_FINISH);
    assign overflow  = scan_done & ovf_flag;

    // Entry being reported is the final one allowed.
    assign last_entry = (entry_cnt == ECW'(OBJ_COUNT - 1));
    assign last_hit   = (hit_cnt == HCW'(HIT_MAX - 1));

    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            obank     <= 1'b0;
            entry_cnt <= '0;
            hit_cnt   <= '0;
            ovf_flag  <= 1'b0;
        end else begin
            // Bank swap, visible the cycle after the pulse.
            if (frame_start) begin
                obank <= ~obank;
            end
            case (state)
                S_IDLE: begin
                    if (line_start) begin
                        state     <= S_SCAN;
                        entry_cnt <= '0;
                        hit_cnt   <= '0;
                        ovf_flag  <= 1'b0;
                    end
                end
                S_SCAN: begin
                    if (entry_done) begin
                        entry_cnt <= entry_cnt + 1'b1;
                        if (entry_hit) begin
                            hit_cnt <= hit_cnt + 1'b1;
                        end
                        // End mark or table size reached.
                        if (entry_last || last_entry) begin
                            state <= S_FINISH;
                        end
                        // Hit limit wins and flags the overflow.
                        if (entry_hit && last_hit) begin
                            state    <= S_FINISH;
                            ovf_flag <= 1'b1;
                        end
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Line number stays fixed for the whole scan.
    always_ff @(posedge clk_cpu) begin
        if (state == S_IDLE && line_start) begin
            scan_line <= line;
        end
    end

    // Line timing must leave room for the scan to finish.
    a_line_idle: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        line_start |-> (state == S_IDLE))
        else $error("line_start while a scan is running");

    // Swapping banks under a running scan would mix two tables.
    a_frame_idle: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        frame_start |-> (state == S_IDLE))
        else $error("frame_start while a scan is running");

endmodule

`default_nettype wire

// ==== src/obj_fmt_pkg.sv ====
// ************************************************************
// Object entry format
// Word layout of one table entry, end marker and height test.
// ************************************************************
`default_nettype none

package obj_fmt_pkg;

    // Each entry takes four consecutive words.
    localparam int WORDS_PER_OBJ = 4;
    localparam int WIDX_W = $clog2(WORDS_PER_OBJ);

    // Word index inside one entry.
    typedef logic [WIDX_W-1:0] widx_t;

    localparam widx_t WIDX_X    = 0;
    localparam widx_t WIDX_Y    = 1;
    localparam widx_t WIDX_CODE = 2;
    localparam widx_t WIDX_ATTR = 3;

    // Upper byte of the attribute word that closes the table.
    localparam logic [7:0] END_MARK = 8'hFF;

    // All objects are the same height, in lines.
    localparam int OBJ_HEIGHT = 16;

    // Line wraps around the 1024-line space, so objects near the bottom show at the top.
    function automatic logic obj_covers(obj_cfg_pkg::pos_t line, obj_cfg_pkg::pos_t y);
        obj_cfg_pkg::pos_t diff;
        diff = line - y;
        return int'(diff) < OBJ_HEIGHT;
    endfunction

endpackage

`default_nettype wire

// ==== src/obj_ram.sv ====
// ************************************************************
// Object table RAM
// Two banks of object entries: a byte-lane CPU port on one side
// and a read-only scanner port on the visible bank.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_ram (
    input  wire                     clk_cpu,
    input  wire                     arst_n,
    input  wire                     obank,
    // CPU side.
    input  wire                     cs,
    input  wire [1:0]               dsn,
    input  wire                     main_rnw,
    input  wire obj_cfg_pkg::cpu_addr_t main_addr,
    input  wire obj_cfg_pkg::word_t main_dout,
    output logic                    ok,
    output obj_cfg_pkg::word_t      dout2cpu,
    // Scanner side.
    input  wire obj_cfg_pkg::scan_addr_t scan_addr,
    output obj_cfg_pkg::word_t      scan_dout
);

    import obj_cfg_pkg::*;

    logic [1:0] we;
    cpu_addr_t  cpu_ram_addr;
    cpu_addr_t  scan_ram_addr;

    // Byte enables are active low.
    // Only a write cycle may touch the array.
    assign we = ~dsn & {2{cs & ~main_rnw}};

    // With bit 12 low the CPU lands on the back bank, which is obank.
    assign cpu_ram_addr = {obank ^ main_addr[12], main_addr[11:0]};

    // Scanner always sees the front bank.
    assign scan_ram_addr = {~obank, scan_addr};

    // Read data is ready one cycle after cs, in step with ok.
    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            ok <= 1'b0;
        end else begin
            ok <= cs;
        end
    end

    dual_port_ram #(.DW(8), .AW($bits(cpu_addr_t))) u_low (
        .clk_cpu (clk_cpu),
        .data0   (main_dout[7:0]),
        .addr0   (cpu_ram_addr),
        .we0     (we[0]),
        .q0      (dout2cpu[7:0]),
        .data1   (8'd0),
        .addr1   (scan_ram_addr),
        .we1     (1'b0),
        .q1      (scan_dout[7:0])
    );

    dual_port_ram #(.DW(8), .AW($bits(cpu_addr_t))) u_high (
        .clk_cpu (clk_cpu),
        .data0   (main_dout[15:8]),
        .addr0   (cpu_ram_addr),
        .we0     (we[1]),
        .q0      (dout2cpu[15:8]),
        .data1   (8'd0),
        .addr1   (scan_ram_addr),
        .we1     (1'b0),
        .q1      (scan_dout[15:8])
    );

    // A CPU write with no byte lane selected points to a bus fault upstream.
    a_write_lane: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        (cs && !main_rnw) |-> (dsn != 2'b11))
        else $error("CPU write with no byte lane enabled");

endmodule

`default_nettype wire

// ==== src/obj_scan.sv ====
// ************************************************************
// Object scanner
// Fetches entries word by word from the front bank and tests
// each one against the current line.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_scan (
    input  wire                     clk_cpu,
    input  wire                     arst_n,
    input  wire                     scan_run,
    input  wire obj_cfg_pkg::pos_t  scan_line,
    input  wire obj_cfg_pkg::word_t scan_dout,
    output obj_cfg_pkg::scan_addr_t scan_addr,
    output logic                    entry_done,
    output logic                    entry_hit,
    output logic                    entry_last,
    output obj_cfg_pkg::pos_t       hit_x,
    output obj_cfg_pkg::word_t      hit_code,
    output obj_cfg_pkg::word_t      hit_attr
);

    import obj_cfg_pkg::*;
    import obj_fmt_pkg::*;

    scan_addr_t addr_cnt;
    logic       rd_valid;
    widx_t      rd_idx;
    logic       take;
    logic       take_attr;
    logic       is_end;
    pos_t       x_reg;
    pos_t       y_reg;
    word_t      code_reg;

    // One address per cycle.
    assign scan_addr = addr_cnt;

    // Data returning after scan_run drops belongs to a dropped fetch.
    assign take      = rd_valid & scan_run;
    assign take_attr = take & (rd_idx == WIDX_ATTR);

    // End mark sits in the upper byte of the attribute word.
    assign is_end = (scan_dout[15:8] == END_MARK);

    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            addr_cnt   <= '0;
            rd_valid   <= 1'b0;
            rd_idx     <= WIDX_X;
            entry_done <= 1'b0;
            entry_hit  <= 1'b0;
            entry_last <= 1'b0;
        end else begin
            // Read latency is one cycle, so index and valid trail the address.
            rd_valid <= scan_run;
            rd_idx   <= addr_cnt[WIDX_W-1:0];
            if (scan_run) begin
                addr_cnt <= addr_cnt + 1'b1;
            end else begin
                addr_cnt <= '0;
            end
            entry_done <= take_attr;
            if (take_attr) begin
                entry_last <= is_end;
                // An end-marked entry never counts as a hit.
                entry_hit  <= obj_covers(scan_line, y_reg) & ~is_end;
            end
        end
    end

    // Steer each returning word into its field.
    always_ff @(posedge clk_cpu) begin
        if (take) begin
            case (rd_idx)
                WIDX_X:    x_reg    <= scan_dout[$bits(pos_t)-1:0];
                WIDX_Y:    y_reg    <= scan_dout[$bits(pos_t)-1:0];
                WIDX_CODE: code_reg <= scan_dout;
                default:   ;
            endcase
        end
        // Outputs hold until the next entry completes.
        if (take_attr) begin
            hit_x    <= x_reg;
            hit_code <= code_reg;
            hit_attr <= scan_dout;
        end
    end

    // Coverage test needs one line number for the whole walk.
    a_line_stable: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        (scan_run && $past(scan_run)) |-> $stable(scan_line))
        else $error("scan_line changed during a scan");

endmodule

`default_nettype wire

// ==== src/obj_top.sv ====
// ************************************************************
// Object table top level
// Joins the control FSM, the two-bank table and the scanner.
// ************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_top #(
    parameter int OBJ_COUNT = obj_cfg_pkg::DEF_OBJ_COUNT,
    parameter int HIT_MAX   = obj_cfg_pkg::DEF_HIT_MAX
) (
    input  wire                     clk_cpu,
    input  wire                     arst_n,
    input  wire                     frame_start,
    input  wire                     line_start,
    input  wire obj_cfg_pkg::pos_t  line,
    // CPU port.
    input  wire                     cs,
    input  wire [1:0]               dsn,
    input  wire                     main_rnw,
    input  wire obj_cfg_pkg::cpu_addr_t main_addr,
    input  wire obj_cfg_pkg::word_t main_dout,
    output logic                    ok,
    output obj_cfg_pkg::word_t      dout2cpu,
    // Scan results.
    output logic                    hit_valid,
    output obj_cfg_pkg::pos_t       hit_x,
    output obj_cfg_pkg::word_t      hit_code,
    output obj_cfg_pkg::word_t      hit_attr,
    output logic                    scan_done,
    output logic                    overflow
);

    import obj_cfg_pkg::*;

    logic       obank;
    logic       scan_run;
    pos_t       scan_line;
    scan_addr_t scan_addr;
    word_t      scan_dout;
    logic       entry_done;
    logic       entry_hit;
    logic       entry_last;

    obj_ctrl #(.OBJ_COUNT(OBJ_COUNT), .HIT_MAX(HIT_MAX)) u_ctrl (
        .clk_cpu     (clk_cpu),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .line_start  (line_start),
        .line        (line),
        .entry_done  (entry_done),
        .entry_hit   (entry_hit),
        .entry_last  (entry_last),
        .obank       (obank),
        .scan_run    (scan_run),
        .scan_line   (scan_line),
        .hit_valid   (hit_valid),
        .scan_done   (scan_done),
        .overflow    (overflow)
    );

    obj_ram u_ram (
        .clk_cpu   (clk_cpu),
        .arst_n    (arst_n),
        .obank     (obank),
        .cs        (cs),
        .dsn       (dsn),
        .main_rnw  (main_rnw),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .ok        (ok),
        .dout2cpu  (dout2cpu),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout)
    );

    obj_scan u_scan (
        .clk_cpu    (clk_cpu),
        .arst_n     (arst_n),
        .scan_run   (scan_run),
        .scan_line  (scan_line),
        .scan_dout  (scan_dout),
        .scan_addr  (scan_addr),
        .entry_done (entry_done),
        .entry_hit  (entry_hit),
        .entry_last (entry_last),
        .hit_x      (hit_x),
        .hit_code   (hit_code),
        .hit_attr   (hit_attr)
    );

endmodule

`default_nettype wire
